// File: chdr_framer_pkg.sv
// ------------------------------
// Shared constants and types for the CHDR framer
// CHDR word fixed at 64 bits, no wider header+timestamp words
// Gate holds 2^GATE_AW words, one slot always kept free
// so a packet may be at most 31 words long
// ------------------------------
package chdr_framer_pkg;

  // ------------------------------
  // Bus widths
  // ------------------------------
  localparam int CHDR_W  = 64;  // CHDR word width
  localparam int TUSER_W = 4;   // Context field code width

  // Context field codes carried on tuser
  localparam logic [TUSER_W-1:0] FIELD_HDR   = 4'd0;
  localparam logic [TUSER_W-1:0] FIELD_TS    = 4'd2;
  localparam logic [TUSER_W-1:0] FIELD_MDATA = 4'd3;

  // Packet type codes in the header
  localparam logic [2:0] PKT_TYPE_DATA    = 3'd6;
  localparam logic [2:0] PKT_TYPE_DATA_TS = 3'd7;

  // Context packets allowed ahead of payload packets (prefetch of one)
  localparam int CTXT_AHEAD_MAX = 2;

  // ------------------------------
  // Packet gate sizing
  // ------------------------------
  localparam int GATE_AW    = 5;
  localparam int GATE_DEPTH = 1 << GATE_AW;

  // ------------------------------
  // Framing FSM state codes
  // ------------------------------
  localparam logic [2:0] ST_HDR       = 3'd0;  // Header word
  localparam logic [2:0] ST_TS        = 3'd1;  // Timestamp word
  localparam logic [2:0] ST_MDATA     = 3'd2;  // Metadata words
  localparam logic [2:0] ST_BODY      = 3'd3;  // Payload words
  localparam logic [2:0] ST_DROP_CTXT = 3'd4;  // Flush rest of context
  localparam logic [2:0] ST_DROP_PYLD = 3'd5;  // Flush whole payload
  localparam logic [2:0] ST_TERMINATE = 3'd6;  // Error word to the gate

  // CHDR header word, raw or by field
  typedef union packed {
    logic [CHDR_W-1:0] raw;
    struct packed {
      logic [5:0]  vc;         // Virtual channel
      logic        eob;        // End of burst
      logic        eov;        // End of vector
      logic [2:0]  pkt_type;   // Packet type
      logic [4:0]  num_mdata;  // Metadata word count
      logic [15:0] seq_num;    // Sequence number
      logic [15:0] length;     // Packet length in bytes
      logic [15:0] dst_epid;   // Destination endpoint
    } fields;
  } chdr_hdr_t;

endpackage

// File: chdr_stream_if.sv
// ------------------------------
// Valid/ready stream between framer blocks
// Word moves when valid and ready are high on a rising edge
// Source holds data, last, error while valid waits for ready
// ------------------------------
`timescale 1ns/10ps

interface chdr_stream_if;
  import chdr_framer_pkg::*;

  logic [CHDR_W-1:0] data;
  logic              last;   // Final word of a packet
  logic              error;  // Packet is bad, discard it
  logic              valid;
  logic              ready;

  // Producer side
  modport src (
    output data, last, error, valid,
    input  ready
  );

  // Consumer side
  modport dst (
    input  data, last, error, valid,
    output ready
  );

endinterface

// File: ctxt_pyld_admit.sv
// ------------------------------
// Admits context and payload packets in step
// Payload passes only after its context packet
// Context may lead payload by CTXT_AHEAD_MAX - 1 packets
// Counters are 3 bits, lead compare relies on wrap
// ------------------------------
`timescale 1ns/10ps

module ctxt_pyld_admit (
  input  logic                                axis_chdr_clk,
  input  logic                                axis_chdr_rst,
  input  logic [chdr_framer_pkg::CHDR_W-1:0]  i_ctxt_tdata,
  input  logic [chdr_framer_pkg::TUSER_W-1:0] i_ctxt_tuser,
  input  logic                                i_ctxt_tlast,
  input  logic                                i_ctxt_tvalid,
  output logic                                o_ctxt_tready,
  input  logic [chdr_framer_pkg::CHDR_W-1:0]  i_pyld_tdata,
  input  logic                                i_pyld_tlast,
  input  logic                                i_pyld_tvalid,
  output logic                                o_pyld_tready,
  output logic [chdr_framer_pkg::TUSER_W-1:0] o_ctxt_tuser,
  chdr_stream_if.src                          ctxt_s,
  chdr_stream_if.src                          pyld_s
);
  import chdr_framer_pkg::*;

  logic [2:0] ctxt_pkt_cnt;  // Accepted context packets
  logic [2:0] pyld_pkt_cnt;  // Accepted payload packets
  logic [2:0] ctxt_lead;
  logic       pass_ctxt;
  logic       pass_pyld;

  // ------------------------------
  // Packet counters
  // ------------------------------
  always_ff @(posedge axis_chdr_clk) begin
    if (axis_chdr_rst) begin
      ctxt_pkt_cnt <= 3'd0;
      pyld_pkt_cnt <= 3'd0;
    end else begin
      if (i_ctxt_tvalid && o_ctxt_tready && i_ctxt_tlast)
        ctxt_pkt_cnt <= ctxt_pkt_cnt + 3'd1;  // Context packet done
      if (i_pyld_tvalid && o_pyld_tready && i_pyld_tlast)
        pyld_pkt_cnt <= pyld_pkt_cnt + 3'd1;  // Payload packet done
    end
  end

  assign ctxt_lead = ctxt_pkt_cnt - pyld_pkt_cnt;
  assign pass_pyld = (ctxt_lead != 3'd0);                 // Its context is in
  assign pass_ctxt = (ctxt_lead < 3'(CTXT_AHEAD_MAX));    // Room to prefetch

  // Context path, error never set here
  assign ctxt_s.data   = i_ctxt_tdata;
  assign ctxt_s.last   = i_ctxt_tlast;
  assign ctxt_s.error  = 1'b0;
  assign ctxt_s.valid  = i_ctxt_tvalid && pass_ctxt;
  assign o_ctxt_tready = ctxt_s.ready && pass_ctxt;
  assign o_ctxt_tuser  = i_ctxt_tuser;  // Field code rides beside the stream

  // Payload path
  assign pyld_s.data   = i_pyld_tdata;
  assign pyld_s.last   = i_pyld_tlast;
  assign pyld_s.error  = 1'b0;
  assign pyld_s.valid  = i_pyld_tvalid && pass_pyld;
  assign o_pyld_tready = pyld_s.ready && pass_pyld;

endmodule

// File: chdr_frame_fsm.sv
// ------------------------------
// Framing FSM, context words then payload words
// Checks timestamp and metadata words against the header
// Malformed pair is consumed whole, one error word is sent
// to the gate and the error count goes up
// Outputs are combinational from inputs within a state
// ------------------------------
`timescale 1ns/10ps

module chdr_frame_fsm (
  input  logic                                axis_chdr_clk,
  input  logic                                axis_chdr_rst,
  chdr_stream_if.dst                          ctxt_s,
  chdr_stream_if.dst                          pyld_s,
  input  logic [chdr_framer_pkg::TUSER_W-1:0] i_ctxt_tuser,
  chdr_stream_if.src                          frame_s,
  output logic [31:0]                         o_framer_errors
);
  import chdr_framer_pkg::*;

  logic [2:0]         state;
  logic [4:0]         mdata_pending;  // Metadata words still due
  chdr_hdr_t          hdr;
  logic               ts_due;
  logic [TUSER_W-1:0] exp_code;       // Field code this word needs
  logic               ctx_final;      // Word should carry last
  logic [2:0]         ctx_next;       // Next context state if all well
  logic [2:0]         ctx_dest;       // Next state after this word
  logic               code_ok;
  logic               ctxt_xfer;
  logic               pyld_xfer;

  assign hdr.raw   = ctxt_s.data;
  assign ts_due    = (hdr.fields.pkt_type == PKT_TYPE_DATA_TS);
  assign ctxt_xfer = ctxt_s.valid && ctxt_s.ready;
  assign pyld_xfer = pyld_s.valid && pyld_s.ready;

  // ------------------------------
  // Context word checks
  // ------------------------------
  always_comb begin
    exp_code  = FIELD_HDR;
    ctx_final = 1'b0;
    ctx_next  = ST_MDATA;
    case (state)
      ST_HDR: begin
        exp_code  = FIELD_HDR;
        ctx_final = !ts_due && (hdr.fields.num_mdata == 5'd0);
        ctx_next  = ts_due ? ST_TS : ST_MDATA;
      end
      ST_TS: begin
        exp_code  = FIELD_TS;
        ctx_final = (mdata_pending == 5'd0);  // No metadata after TS
      end
      ST_MDATA: begin
        exp_code  = FIELD_MDATA;
        ctx_final = (mdata_pending == 5'd1);
      end
      default: begin
        exp_code  = FIELD_HDR;
      end
    endcase
    code_ok = (i_ctxt_tuser == exp_code);
    if (ctx_final) begin
      // Last expected here, a missing one means extra lines
      if (!ctxt_s.last)
        ctx_dest = ST_DROP_CTXT;
      else
        ctx_dest = code_ok ? ST_BODY : ST_DROP_PYLD;
    end else begin
      // Last here is premature, context already ended
      if (ctxt_s.last)
        ctx_dest = ST_DROP_PYLD;
      else
        ctx_dest = code_ok ? ctx_next : ST_DROP_CTXT;
    end
  end

  // ------------------------------
  // State and error count
  // ------------------------------
  always_ff @(posedge axis_chdr_clk) begin
    if (axis_chdr_rst) begin
      state           <= ST_HDR;
      mdata_pending   <= 5'd0;
      o_framer_errors <= 32'd0;
    end else begin
      case (state)
        ST_HDR, ST_TS, ST_MDATA: begin
          if (ctxt_xfer) begin
            state <= ctx_dest;
            if (state == ST_HDR)
              mdata_pending <= hdr.fields.num_mdata;  // Load from header
            else if (state == ST_MDATA)
              mdata_pending <= mdata_pending - 5'd1;
          end
        end
        ST_BODY: begin
          if (pyld_xfer && pyld_s.last)
            state <= ST_HDR;  // Pair framed
        end
        ST_DROP_CTXT: begin
          if (ctxt_xfer && ctxt_s.last)
            state <= ST_DROP_PYLD;
        end
        ST_DROP_PYLD: begin
          if (pyld_xfer && pyld_s.last)
            state <= ST_TERMINATE;
        end
        ST_TERMINATE: begin
          if (frame_s.ready) begin
            state           <= ST_HDR;
            o_framer_errors <= o_framer_errors + 32'd1;
          end
        end
        default: state <= ST_HDR;
      endcase
    end
  end

  // ------------------------------
  // Stream steering
  // ------------------------------
  always_comb begin
    frame_s.valid = 1'b0;
    frame_s.last  = 1'b0;
    ctxt_s.ready  = 1'b0;
    pyld_s.ready  = 1'b0;
    case (state)
      ST_HDR, ST_TS, ST_MDATA: begin
        frame_s.valid = ctxt_s.valid;   // Context word forwarded, never last
        ctxt_s.ready  = frame_s.ready;
      end
      ST_BODY: begin
        frame_s.valid = pyld_s.valid;
        frame_s.last  = pyld_s.last;    // Packet ends with the payload
        pyld_s.ready  = frame_s.ready;
      end
      ST_DROP_CTXT: ctxt_s.ready = 1'b1;  // Swallow context
      ST_DROP_PYLD: pyld_s.ready = 1'b1;  // Swallow payload
      ST_TERMINATE: begin
        frame_s.valid = 1'b1;           // Error word rewinds the gate
        frame_s.last  = 1'b1;
      end
      default: frame_s.valid = 1'b0;
    endcase
  end

  assign frame_s.data  = (state == ST_BODY)      ? pyld_s.data :
                         (state == ST_TERMINATE) ? '0 : ctxt_s.data;
  assign frame_s.error = (state == ST_TERMINATE);

endmodule

// File: chdr_packet_gate.sv
// ------------------------------
// Packet gate that releases only whole good packets
// Error word discards the packet written so far
// One slot stays free so packets must be 31 words or less
// Output data is an async read at the read pointer
// ------------------------------
`timescale 1ns/10ps

module chdr_packet_gate (
  input  logic                               axis_chdr_clk,
  input  logic                               axis_chdr_rst,
  chdr_stream_if.dst                         frame_s,
  output logic [chdr_framer_pkg::CHDR_W-1:0] o_chdr_tdata,
  output logic                               o_chdr_tlast,
  output logic                               o_chdr_tvalid,
  input  logic                               i_chdr_tready
);
  import chdr_framer_pkg::*;

  // ------------------------------
  // Storage
  // ------------------------------
  logic [CHDR_W-1:0]  mem_data [GATE_DEPTH];
  logic               mem_last [GATE_DEPTH];

  logic [GATE_AW-1:0] wr_ptr;  // Next free slot
  logic [GATE_AW-1:0] cm_ptr;  // End of committed packets
  logic [GATE_AW-1:0] rd_ptr;  // Next word out
  logic               full;
  logic               wr_xfer;
  logic               rd_xfer;

  assign full          = ((wr_ptr + GATE_AW'(1)) == rd_ptr);
  assign frame_s.ready = !full;
  assign wr_xfer       = frame_s.valid && frame_s.ready;
  assign rd_xfer       = o_chdr_tvalid && i_chdr_tready;

  // Payload memory written on good words only
  always_ff @(posedge axis_chdr_clk) begin
    if (wr_xfer && !frame_s.error) begin
      mem_data[wr_ptr] <= frame_s.data;
      mem_last[wr_ptr] <= frame_s.last;
    end
  end

  // ------------------------------
  // Write and commit pointers
  // ------------------------------
  always_ff @(posedge axis_chdr_clk) begin
    if (axis_chdr_rst) begin
      wr_ptr <= '0;
      cm_ptr <= '0;
    end else if (wr_xfer) begin
      if (frame_s.error) begin
        wr_ptr <= cm_ptr;  // Rewind drops the partial packet
      end else begin
        wr_ptr <= wr_ptr + GATE_AW'(1);
        if (frame_s.last)
          cm_ptr <= wr_ptr + GATE_AW'(1);  // Whole packet visible next cycle
      end
    end
  end

  // Read side never passes the commit pointer
  always_ff @(posedge axis_chdr_clk) begin
    if (axis_chdr_rst)
      rd_ptr <= '0;
    else if (rd_xfer)
      rd_ptr <= rd_ptr + GATE_AW'(1);
  end

  assign o_chdr_tvalid = (rd_ptr != cm_ptr);
  assign o_chdr_tdata  = mem_data[rd_ptr];  // Slot held stable until read
  assign o_chdr_tlast  = mem_last[rd_ptr];

endmodule

// File: chdr_framer.sv
// ------------------------------
// CHDR framer top, single clock
// Context packet must come with its payload packet
// Output last taken from the payload's last word
// Malformed pairs are dropped and counted
// ------------------------------
`timescale 1ns/10ps

module chdr_framer (
  input  logic                                axis_chdr_clk,
  input  logic                                axis_chdr_rst,
  // Context stream in
  input  logic [chdr_framer_pkg::CHDR_W-1:0]  i_ctxt_tdata,
  input  logic [chdr_framer_pkg::TUSER_W-1:0] i_ctxt_tuser,
  input  logic                                i_ctxt_tlast,
  input  logic                                i_ctxt_tvalid,
  output logic                                o_ctxt_tready,
  // Payload stream in
  input  logic [chdr_framer_pkg::CHDR_W-1:0]  i_pyld_tdata,
  input  logic                                i_pyld_tlast,
  input  logic                                i_pyld_tvalid,
  output logic                                o_pyld_tready,
  // CHDR stream out
  output logic [chdr_framer_pkg::CHDR_W-1:0]  o_chdr_tdata,
  output logic                                o_chdr_tlast,
  output logic                                o_chdr_tvalid,
  input  logic                                i_chdr_tready,
  // Status
  output logic [31:0]                         o_framer_errors
);
  import chdr_framer_pkg::*;

  logic [TUSER_W-1:0] ctxt_tuser;  // Admitted field code

  chdr_stream_if ctxt_s ();
  chdr_stream_if pyld_s ();
  chdr_stream_if frame_s ();

  ctxt_pyld_admit u_admit (
    .axis_chdr_clk (axis_chdr_clk),
    .axis_chdr_rst (axis_chdr_rst),
    .i_ctxt_tdata  (i_ctxt_tdata),
    .i_ctxt_tuser  (i_ctxt_tuser),
    .i_ctxt_tlast  (i_ctxt_tlast),
    .i_ctxt_tvalid (i_ctxt_tvalid),
    .o_ctxt_tready (o_ctxt_tready),
    .i_pyld_tdata  (i_pyld_tdata),
    .i_pyld_tlast  (i_pyld_tlast),
    .i_pyld_tvalid (i_pyld_tvalid),
    .o_pyld_tready (o_pyld_tready),
    .o_ctxt_tuser  (ctxt_tuser),
    .ctxt_s        (ctxt_s.src),
    .pyld_s        (pyld_s.src)
  );

  chdr_frame_fsm u_fsm (
    .axis_chdr_clk   (axis_chdr_clk),
    .axis_chdr_rst   (axis_chdr_rst),
    .ctxt_s          (ctxt_s.dst),
    .pyld_s          (pyld_s.dst),
    .i_ctxt_tuser    (ctxt_tuser),
    .frame_s         (frame_s.src),
    .o_framer_errors (o_framer_errors)
  );

  chdr_packet_gate u_gate (
    .axis_chdr_clk (axis_chdr_clk),
    .axis_chdr_rst (axis_chdr_rst),
    .frame_s       (frame_s.dst),
    .o_chdr_tdata  (o_chdr_tdata),
    .o_chdr_tlast  (o_chdr_tlast),
    .o_chdr_tvalid (o_chdr_tvalid),
    .i_chdr_tready (i_chdr_tready)
  );

endmodule

// File: tb_chdr_framer_checker.sv
// ------------------------------
// Output stream checks, bound into the framer top
// Assumes synchronous active-high reset
// ------------------------------
`timescale 1ns/10ps

module tb_chdr_framer_checker (
  input logic                               axis_chdr_clk,
  input logic                               axis_chdr_rst,
  input logic [chdr_framer_pkg::CHDR_W-1:0] i_chdr_tdata,
  input logic                               i_chdr_tlast,
  input logic                               i_chdr_tvalid,
  input logic                               i_chdr_tready,
  input logic [31:0]                        i_framer_errors
);

  // Stalled word must not move or vanish
  a_hold_stall: assert property (
    @(posedge axis_chdr_clk) disable iff (axis_chdr_rst)
    (i_chdr_tvalid && !i_chdr_tready) |=>
      (i_chdr_tvalid && $stable(i_chdr_tdata) && $stable(i_chdr_tlast))
  ) else $error("Output word changed while stalled");

  a_err_monotonic: assert property (
    @(posedge axis_chdr_clk) disable iff (axis_chdr_rst)
    i_framer_errors >= $past(i_framer_errors)  // Counter only climbs
  ) else $error("Error counter went down");

  // Gate empty right after reset
  a_idle_after_rst: assert property (
    @(posedge axis_chdr_clk) axis_chdr_rst |=> !i_chdr_tvalid
  ) else $error("Output valid high in the cycle after reset");

endmodule

// File: tb_chdr_framer.sv
// ------------------------------
// Testbench for the CHDR framer
// Random pairs from a fixed seed, about 1 in 3 malformed
// Queue model holds expected output words and error count
// Stops at the first mismatch or timeout
// ------------------------------
`timescale 1ns/10ps

module tb_chdr_framer;
  import chdr_framer_pkg::*;

  localparam int TIMEOUT_CYC = 2000;
  localparam int ALL_PKTS    = 1 << 30;

  logic axis_chdr_clk = 1'b0;
  logic axis_chdr_rst;
  logic [CHDR_W-1:0] i_ctxt_tdata, i_pyld_tdata, o_chdr_tdata;
  logic [TUSER_W-1:0] i_ctxt_tuser;
  logic i_ctxt_tlast, i_ctxt_tvalid, o_ctxt_tready;
  logic i_pyld_tlast, i_pyld_tvalid, o_pyld_tready;
  logic o_chdr_tlast, o_chdr_tvalid, i_chdr_tready;
  logic [31:0] o_framer_errors;

  integer seed = 32'hf9ac_5503;
  integer bp_seed;          // Back-pressure draws, split off the main seed
  logic   bp_en;
  int     exp_errors;
  int     r;
  int     waited;

  // Stimulus queues and the expected output
  logic [CHDR_W-1:0]  ctxt_data_q[$], pyld_data_q[$], exp_data_q[$];
  logic [TUSER_W-1:0] ctxt_user_q[$];
  logic               ctxt_last_q[$], pyld_last_q[$], exp_last_q[$];

  always #4 axis_chdr_clk = ~axis_chdr_clk;  // 8 ns period

  chdr_framer DUT (.*);

  bind chdr_framer tb_chdr_framer_checker u_checker (
    .axis_chdr_clk (axis_chdr_clk), .axis_chdr_rst (axis_chdr_rst),
    .i_chdr_tdata  (o_chdr_tdata),  .i_chdr_tlast  (o_chdr_tlast),
    .i_chdr_tvalid (o_chdr_tvalid), .i_chdr_tready (i_chdr_tready),
    .i_framer_errors (o_framer_errors)
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Waits on the posedge where the offered word is taken
  task automatic wait_accept(input bit is_ctxt);
    int n;
    n = 0;
    @(posedge axis_chdr_clk);
    while (!(is_ctxt ? o_ctxt_tready : o_pyld_tready)) begin
      n++;
      if (n > TIMEOUT_CYC)
        stop_on_error(is_ctxt ? "Timeout: context word never accepted"
                              : "Timeout: payload word never accepted");
      @(posedge axis_chdr_clk);
    end
  endtask

  task automatic send_ctxt_words(input int max_pkts);
    int pkts;
    pkts = 0;
    while (ctxt_data_q.size() > 0 && pkts < max_pkts) begin
      i_ctxt_tdata  = ctxt_data_q[0];
      i_ctxt_tuser  = ctxt_user_q[0];
      i_ctxt_tlast  = ctxt_last_q[0];
      i_ctxt_tvalid = 1'b1;
      wait_accept(1'b1);
      if (ctxt_last_q[0])
        pkts++;
      ctxt_data_q.delete(0);
      ctxt_user_q.delete(0);
      ctxt_last_q.delete(0);
      @(negedge axis_chdr_clk);
    end
    i_ctxt_tvalid = 1'b0;
  endtask

  task automatic send_pyld_words();
    while (pyld_data_q.size() > 0) begin
      i_pyld_tdata  = pyld_data_q[0];
      i_pyld_tlast  = pyld_last_q[0];
      i_pyld_tvalid = 1'b1;
      wait_accept(1'b0);
      pyld_data_q.delete(0);
      pyld_last_q.delete(0);
      @(negedge axis_chdr_clk);
    end
    i_pyld_tvalid = 1'b0;
  endtask

  // Mode 0 good, 1 wrong field code, 2 premature last, 3 extra line
  task automatic build_pair(input int mode);
    chdr_hdr_t          hdr;
    logic [CHDR_W-1:0]  words[$];
    logic [TUSER_W-1:0] codes[$];
    logic [CHDR_W-1:0]  pdata;
    int                 n_pl;
    int                 idx;
    int                 i;
    hdr.raw              = {$random(seed), $random(seed)};
    hdr.fields.pkt_type  = ($random(seed) & 1) ? PKT_TYPE_DATA_TS : PKT_TYPE_DATA;
    hdr.fields.num_mdata = 5'($unsigned($random(seed)) % 4);
    words.push_back(hdr.raw);
    codes.push_back(FIELD_HDR);
    if (hdr.fields.pkt_type == PKT_TYPE_DATA_TS) begin
      words.push_back({$random(seed), $random(seed)});
      codes.push_back(FIELD_TS);  // Timestamp right after header
    end
    for (i = 0; i < int'(hdr.fields.num_mdata); i++) begin
      words.push_back({$random(seed), $random(seed)});
      codes.push_back(FIELD_MDATA);
    end
    if (mode == 2 && words.size() < 2)
      mode = 3;  // Lone header cannot end early
    case (mode)
      1: begin
        idx = int'($unsigned($random(seed)) % words.size());
        codes[idx] = codes[idx] ^ 4'h1;  // HDR to 1, TS and MDATA swap
      end
      2: begin
        idx = 1 + int'($unsigned($random(seed)) % (words.size() - 1));
        while (words.size() > idx) begin
          words.delete(words.size() - 1);
          codes.delete(codes.size() - 1);
        end
      end
      3: begin
        words.push_back({$random(seed), $random(seed)});
        codes.push_back(FIELD_MDATA);  // One past the header's count
      end
      default: ;
    endcase
    n_pl = 1 + int'($unsigned($random(seed)) % 16);
    for (i = 0; i < words.size(); i++) begin
      ctxt_data_q.push_back(words[i]);
      ctxt_user_q.push_back(codes[i]);
      ctxt_last_q.push_back(i == words.size() - 1);
      if (mode == 0) begin
        exp_data_q.push_back(words[i]);
        exp_last_q.push_back(1'b0);  // Context never ends the packet
      end
    end
    for (i = 0; i < n_pl; i++) begin
      pdata = {$random(seed), $random(seed)};
      pyld_data_q.push_back(pdata);
      pyld_last_q.push_back(i == n_pl - 1);
      if (mode == 0) begin
        exp_data_q.push_back(pdata);
        exp_last_q.push_back(i == n_pl - 1);
      end
    end
    if (mode != 0)
      exp_errors++;  // Whole pair dropped and counted
  endtask

  // Back-pressure, output ready high about a third of the time
  always @(negedge axis_chdr_clk)
    i_chdr_tready = bp_en ? (($unsigned($random(bp_seed)) % 3) == 0) : 1'b1;

  // Output monitor against the model
  always @(posedge axis_chdr_clk) begin
    if (!axis_chdr_rst && o_chdr_tvalid && i_chdr_tready) begin
      assert (exp_data_q.size() > 0)
        else stop_on_error($sformatf("ERROR %0t: unexpected output word %h",
                                     $time, o_chdr_tdata));
      assert (o_chdr_tdata == exp_data_q[0] && o_chdr_tlast == exp_last_q[0])
        else stop_on_error($sformatf("ERROR %0t: exp %h last %b, got %h last %b", $time,
                                     exp_data_q[0], exp_last_q[0], o_chdr_tdata, o_chdr_tlast));
      exp_data_q.delete(0);
      exp_last_q.delete(0);
    end
  end

  initial begin
    axis_chdr_rst = 1'b1;
    {i_ctxt_tdata, i_ctxt_tuser, i_ctxt_tlast, i_ctxt_tvalid} = '0;
    {i_pyld_tdata, i_pyld_tlast, i_pyld_tvalid} = '0;
    i_chdr_tready = 1'b1;
    bp_en         = 1'b0;
    exp_errors    = 0;
    bp_seed       = $random(seed);
    repeat (10) @(posedge axis_chdr_clk);
    @(negedge axis_chdr_clk);
    axis_chdr_rst = 1'b0;

    // Payload alone is held back
    build_pair(0);
    i_pyld_tdata  = pyld_data_q[0];
    i_pyld_tlast  = pyld_last_q[0];
    i_pyld_tvalid = 1'b1;
    repeat (20) begin
      @(posedge axis_chdr_clk);
      assert (!o_pyld_tready && !o_chdr_tvalid && o_framer_errors == 32'd0)
        else stop_on_error($sformatf("ERROR %0t: payload taken without its context", $time));
    end
    @(negedge axis_chdr_clk);
    fork
      send_ctxt_words(ALL_PKTS);
      send_pyld_words();
    join

    // Contexts without payload, FSM waits in body so the next one stalls
    repeat (3) build_pair(0);
    send_ctxt_words(1);
    i_ctxt_tdata  = ctxt_data_q[0];
    i_ctxt_tuser  = ctxt_user_q[0];
    i_ctxt_tlast  = ctxt_last_q[0];
    i_ctxt_tvalid = 1'b1;
    repeat (20) begin
      @(posedge axis_chdr_clk);
      assert (!o_ctxt_tready)
        else stop_on_error($sformatf("ERROR %0t: context accepted ahead of payload", $time));
    end
    @(negedge axis_chdr_clk);
    fork
      send_ctxt_words(ALL_PKTS);
      send_pyld_words();
    join

    // Random pairs in batches, back-pressure from the sixth batch on
    for (int b = 0; b < 15; b++) begin
      bp_en = (b >= 5);
      repeat (4) begin
        r = int'($unsigned($random(seed)) % 8);
        build_pair(r < 5 ? 0 : r - 4);
      end
      fork
        send_ctxt_words(ALL_PKTS);
        send_pyld_words();
      join
    end

    bp_en  = 1'b0;
    waited = 0;
    while (exp_data_q.size() > 0 || o_framer_errors != 32'(exp_errors)) begin
      waited++;
      if (waited > TIMEOUT_CYC)
        stop_on_error("Timeout waiting for the output and error count to settle");
      @(posedge axis_chdr_clk);
    end
    repeat (20) @(negedge axis_chdr_clk);  // Nothing extra may follow
    assert (o_framer_errors == 32'(exp_errors) && !o_chdr_tvalid)
      else stop_on_error($sformatf("ERROR %0t: errors exp %0d got %0d", $time,
                                   exp_errors, o_framer_errors));
    $display("** PASS **");
    $finish;
  end

endmodule

// File: sources.f
chdr_framer_pkg.sv
chdr_stream_if.sv
ctxt_pyld_admit.sv
chdr_frame_fsm.sv
chdr_packet_gate.sv
chdr_framer.sv
tb_chdr_framer_checker.sv
tb_chdr_framer.sv

// File: Makefile
# Verilator build and run of the CHDR framer testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sources.f --top-module tb_chdr_framer -o tb_chdr_framer
	./obj_dir/tb_chdr_framer | tee /dev/stderr | grep -F '** PASS **' > /dev/null

clean:
	rm -rf obj_dir
